// File: Makefile
# Verilator build and run for the HBM traffic generator testbench

VERILATOR ?= verilator
TOP       ?= tb_hbm_traffic
FILELIST  ?= build.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --binary --timing --assert -j 0
PASS_MSG  ?= Simulation completed successfully

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "Variables: VERILATOR TOP FILELIST OBJ_DIR VFLAGS PASS_MSG"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qF "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// File: build.f
hw/hbm_traffic_pkg.sv
hw/traffic_ctrl_if.sv
hw/traffic_ctrl.sv
hw/addr_gen.sv
hw/read_engine.sv
hw/write_engine.sv
hw/hbm_traffic_top.sv
tb/hbm_slave_model.sv
tb/tb_hbm_traffic.sv

// File: hw/addr_gen.sv
module addr_gen #(
    parameter int port_index    = 0,
    parameter int region_bursts = 524288
) (
    input  logic                              axi_aclk,
    input  logic                              axi_aresetn,
    input  logic                              step,
    input  logic                              step_en,
    output logic [hbm_traffic_pkg::ADDR_W-1:0] addr
);
    import hbm_traffic_pkg::*;

    logic [ADDR_W-1:0] base;
    logic [ADDR_W-1:0] last_addr;

    assign base      = ADDR_W'(port_index) * REGION_SIZE;
    assign last_addr = base + ADDR_W'(region_bursts - 1) * BURST_BYTES;  // Final burst slot

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            addr <= base;
        else if (step)
        begin
            // Fixed mode and end of region both go back to base
            if (!step_en || (addr == last_addr))
                addr <= base;
            else
                addr <= addr + BURST_BYTES;
        end
    end

endmodule

// File: hw/hbm_traffic_pkg.sv
package hbm_traffic_pkg;

    ////////////////////////////////////////
    // Bus and burst geometry
    ////////////////////////////////////////

    localparam int ADDR_W    = 33;
    localparam int DATA_W    = 256;
    localparam int BURST_LEN = 16;          // INCR, 32 bytes per beat

    // 16 beats of 32 bytes per burst
    localparam logic [ADDR_W-1:0] BURST_BYTES = 33'h200;
    localparam logic [ADDR_W-1:0] REGION_SIZE = 33'h10000000;  // One pseudo-channel

    ////////////////////////////////////////
    // Limits and pattern
    ////////////////////////////////////////

    localparam int MAX_OUTSTANDING = 32;    // Bursts in flight per engine
    localparam int CNT_W           = 6;     // Holds 0..MAX_OUTSTANDING

    localparam logic [31:0] DATA_PATTERN = 32'ha5a5a5a5;

    // 3-bit mode codes, only the queued ones are implemented
    typedef enum logic [2:0] {
        QUEUED_READ  = 3'd3,
        QUEUED_WRITE = 3'd4
    } traffic_mode_e;

    // Address channel issue FSM
    typedef enum logic [1:0] {
        IDLE,
        ISSUE,
        HOLD
    } issue_state_e;

endpackage

// File: hw/hbm_traffic_top.sv
module hbm_traffic_top #(
    parameter int port_index    = 0,
    parameter int region_bursts = 524288
) (
    input  logic                               axi_aclk,
    input  logic                               axi_aresetn,
    input  logic                               start,
    input  logic [2:0]                         mode,
    input  logic                               address_inc,
    input  logic [31:0]                        port_mask,
    // AR / R
    output logic [hbm_traffic_pkg::ADDR_W-1:0] araddr,
    output logic                               arvalid,
    input  logic                               arready,
    input  logic [hbm_traffic_pkg::DATA_W-1:0] rdata,
    input  logic                               rlast,
    input  logic                               rvalid,
    output logic                               rready,
    // AW / W / B
    output logic [hbm_traffic_pkg::ADDR_W-1:0] awaddr,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [hbm_traffic_pkg::DATA_W-1:0] wdata,
    output logic                               wlast,
    output logic                               wvalid,
    input  logic                               wready,
    input  logic                               bvalid,
    output logic                               bready,
    output logic                               busy
);
    import hbm_traffic_pkg::*;

    logic [ADDR_W-1:0] rd_addr;
    logic [ADDR_W-1:0] wr_addr;
    logic              rd_step;
    logic              wr_step;

    traffic_ctrl_if ctl_if ();

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////

    traffic_ctrl #(.port_index(port_index)) i_traffic_ctrl (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .start       (start),
        .mode        (mode),
        .address_inc (address_inc),
        .port_mask   (port_mask),
        .ctl         (ctl_if.ctrl),
        .busy        (busy)
    );

    addr_gen #(.port_index(port_index), .region_bursts(region_bursts)) i_rd_addr_gen (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .step        (rd_step),
        .step_en     (ctl_if.addr_step_en),
        .addr        (rd_addr)
    );

    addr_gen #(.port_index(port_index), .region_bursts(region_bursts)) i_wr_addr_gen (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .step        (wr_step),
        .step_en     (ctl_if.addr_step_en),
        .addr        (wr_addr)
    );

    ////////////////////////////////////////
    // Engines
    ////////////////////////////////////////

    read_engine i_read_engine (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ctl         (ctl_if.engine),
        .addr        (rd_addr),
        .step        (rd_step),
        .araddr      (araddr),
        .arvalid     (arvalid),
        .arready     (arready),
        .rlast       (rlast),
        .rvalid      (rvalid),
        .rready      (rready)
    );

    write_engine i_write_engine (
        .axi_aclk    (axi_aclk),
        .axi_aresetn (axi_aresetn),
        .ctl         (ctl_if.engine),
        .addr        (wr_addr),
        .step        (wr_step),
        .awaddr      (awaddr),
        .awvalid     (awvalid),
        .awready     (awready),
        .wdata       (wdata),
        .wlast       (wlast),
        .wvalid      (wvalid),
        .wready      (wready),
        .bvalid      (bvalid),
        .bready      (bready)
    );

endmodule

// File: hw/read_engine.sv
module read_engine (
    input  logic                               axi_aclk,
    input  logic                               axi_aresetn,
    traffic_ctrl_if.engine                     ctl,
    input  logic [hbm_traffic_pkg::ADDR_W-1:0] addr,
    output logic                               step,
    output logic [hbm_traffic_pkg::ADDR_W-1:0] araddr,
    output logic                               arvalid,
    input  logic                               arready,
    input  logic                               rlast,
    input  logic                               rvalid,
    output logic                               rready
);
    import hbm_traffic_pkg::*;

    issue_state_e     state;
    logic [CNT_W-1:0] outstanding;
    logic             ar_done;
    logic             r_done;
    logic             can_issue;
    logic             idle;

    assign ar_done   = arvalid && arready;
    assign r_done    = rvalid && rready && rlast;   // End of one read burst
    assign can_issue = ctl.read_run && (outstanding < CNT_W'(MAX_OUTSTANDING));
    assign idle      = (state == IDLE) && (outstanding == '0);

    assign arvalid       = (state == ISSUE);
    assign araddr        = addr;
    assign step          = ar_done;
    assign rready        = !idle;   // Sink every beat while anything is active
    assign ctl.read_idle = idle;

    ////////////////////////////////////////
    // AR issue FSM
    ////////////////////////////////////////

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:  if (can_issue) state <= ISSUE;
                ISSUE: if (ar_done) state <= HOLD;     // Valid held until accepted
                HOLD:  state <= can_issue ? ISSUE : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    // Bursts in flight, AR and last beat may coincide
    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            outstanding <= '0;
        else
        begin
            case ({ar_done, r_done})
                2'b10:   outstanding <= outstanding + 1'b1;
                2'b01:   outstanding <= outstanding - 1'b1;
                default: outstanding <= outstanding;
            endcase
        end
    end

endmodule

// File: hw/traffic_ctrl.sv
module traffic_ctrl #(
    parameter int port_index = 0
) (
    input  logic         axi_aclk,
    input  logic         axi_aresetn,
    input  logic         start,
    input  logic [2:0]   mode,
    input  logic         address_inc,
    input  logic [31:0]  port_mask,
    traffic_ctrl_if.ctrl ctl,
    output logic         busy
);
    import hbm_traffic_pkg::*;

    traffic_mode_e mode_q;
    traffic_mode_e mode_sel;
    logic          run_req;
    logic          read_go;
    logic          write_go;
    logic          eng_idle;

    // Mode frozen from the first run cycle until the drain is done
    assign mode_sel = busy ? mode_q : traffic_mode_e'(mode);
    assign run_req  = start && port_mask[port_index];
    assign read_go  = run_req && (mode_sel == QUEUED_READ);
    assign write_go = run_req && (mode_sel == QUEUED_WRITE);
    assign eng_idle = ctl.read_idle && ctl.write_idle;

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            ctl.read_run     <= 1'b0;
            ctl.write_run    <= 1'b0;
            ctl.addr_step_en <= 1'b0;
            busy             <= 1'b0;
            mode_q           <= QUEUED_READ;
        end
        else
        begin
            ctl.read_run     <= read_go;
            ctl.write_run    <= write_go;
            ctl.addr_step_en <= address_inc;
            // Run flags cover the cycle before an engine leaves IDLE
            busy <= read_go || write_go || ctl.read_run || ctl.write_run || !eng_idle;
            if (!busy)
                mode_q <= mode_sel;
        end
    end

endmodule

// File: hw/traffic_ctrl_if.sv
interface traffic_ctrl_if;

    logic read_run;       // Read engine may issue
    logic write_run;      // Write engine may issue
    logic read_idle;      // Nothing in flight on the read side
    logic write_idle;
    logic addr_step_en;   // Registered address_inc

    modport ctrl (
        output read_run,
        output write_run,
        output addr_step_en,
        input  read_idle,
        input  write_idle
    );

    modport engine (
        input  read_run,
        input  write_run,
        input  addr_step_en,
        output read_idle,
        output write_idle
    );

endinterface

// File: hw/write_engine.sv
module write_engine (
    input  logic                               axi_aclk,
    input  logic                               axi_aresetn,
    traffic_ctrl_if.engine                     ctl,
    input  logic [hbm_traffic_pkg::ADDR_W-1:0] addr,
    output logic                               step,
    output logic [hbm_traffic_pkg::ADDR_W-1:0] awaddr,
    output logic                               awvalid,
    input  logic                               awready,
    output logic [hbm_traffic_pkg::DATA_W-1:0] wdata,
    output logic                               wlast,
    output logic                               wvalid,
    input  logic                               wready,
    input  logic                               bvalid,
    output logic                               bready
);
    import hbm_traffic_pkg::*;

    issue_state_e                   state;
    logic [CNT_W-1:0]               outstanding;  // AW accepted, B not yet seen
    logic [CNT_W-1:0]               pending;      // AW accepted, data not yet sent
    logic [$clog2(BURST_LEN)-1:0]   beat;
    logic                           aw_done;
    logic                           w_done;
    logic                           b_done;
    logic                           can_issue;
    logic                           idle;

    assign aw_done   = awvalid && awready;
    assign w_done    = wvalid && wready && wlast;
    assign b_done    = bvalid && bready;
    assign can_issue = ctl.write_run && (outstanding < CNT_W'(MAX_OUTSTANDING));
    assign idle      = (state == IDLE) && (outstanding == '0) && (pending == '0);

    assign awvalid        = (state == ISSUE);
    assign awaddr         = addr;
    assign step           = aw_done;
    assign bready         = !idle;
    assign ctl.write_idle = idle;

    ////////////////////////////////////////
    // W channel
    ////////////////////////////////////////

    assign wdata  = {(DATA_W / 32){DATA_PATTERN}};
    assign wvalid = (pending != '0);    // Only behind an accepted AW
    assign wlast  = wvalid && (int'(beat) == BURST_LEN - 1);

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            beat <= '0;
        else if (wvalid && wready)
            beat <= wlast ? '0 : beat + 1'b1;
    end

    // AW issue FSM, same shape as the read side
    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
            state <= IDLE;
        else
        begin
            case (state)
                IDLE:  if (can_issue) state <= ISSUE;
                ISSUE: if (aw_done) state <= HOLD;
                HOLD:  state <= can_issue ? ISSUE : IDLE;
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            pending     <= '0;
            outstanding <= '0;
        end
        else
        begin
            if (aw_done && !w_done)
                pending <= pending + 1'b1;
            else if (!aw_done && w_done)
                pending <= pending - 1'b1;

            if (aw_done && !b_done)
                outstanding <= outstanding + 1'b1;
            else if (!aw_done && b_done)
                outstanding <= outstanding - 1'b1;
        end
    end

endmodule

// File: tb/hbm_slave_model.sv
module hbm_slave_model (
    input  logic                               axi_aclk,
    input  logic                               axi_aresetn,
    input  logic                               hold_resp,   // Withhold all R and B
    input  logic                               arvalid,
    output logic                               arready,
    output logic [hbm_traffic_pkg::DATA_W-1:0] rdata,
    output logic                               rlast,
    output logic                               rvalid,
    input  logic                               rready,
    input  logic                               awvalid,
    output logic                               awready,
    input  logic                               wlast,
    input  logic                               wvalid,
    output logic                               wready,
    output logic                               bvalid,
    input  logic                               bready
);
    import hbm_traffic_pkg::*;

    integer seed = 32'h25e8b5aa;
    int     r_pend;     // Read bursts accepted, data not yet returned
    int     r_beat;
    int     b_pend;     // Write bursts complete, response not yet given

    // Log of accepted transfers since reset
    int ar_count;
    int aw_count;
    int w_beats;
    int wlast_count;
    int rlast_count;
    int b_count;

    always @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            arready     <= 1'b0;
            awready     <= 1'b0;
            wready      <= 1'b0;
            rvalid      <= 1'b0;
            rlast       <= 1'b0;
            rdata       <= '0;
            bvalid      <= 1'b0;
            r_pend      = 0;
            r_beat      = 0;
            b_pend      = 0;
            ar_count    <= 0;
            aw_count    <= 0;
            w_beats     <= 0;
            wlast_count <= 0;
            rlast_count <= 0;
            b_count     <= 0;
        end
        else
        begin
            if (arvalid && arready)
            begin
                r_pend = r_pend + 1;
                ar_count <= ar_count + 1;
            end
            if (rvalid && rready)
            begin
                if (rlast)
                begin
                    r_pend = r_pend - 1;
                    r_beat = 0;
                    rlast_count <= rlast_count + 1;
                end
                else
                    r_beat = r_beat + 1;
            end
            if (awvalid && awready)
                aw_count <= aw_count + 1;
            if (wvalid && wready)
            begin
                w_beats <= w_beats + 1;
                if (wlast)
                begin
                    b_pend = b_pend + 1;
                    wlast_count <= wlast_count + 1;
                end
            end
            if (bvalid && bready)
            begin
                b_pend = b_pend - 1;
                b_count <= b_count + 1;
            end

            // Stall each ready about one cycle in four
            arready <= ($random(seed) & 3) != 0;
            awready <= ($random(seed) & 3) != 0;
            wready  <= ($random(seed) & 3) != 0;

            // A raised valid stays up until it is taken
            rvalid <= (rvalid && !rready) || ((r_pend != 0) && !hold_resp);
            rlast  <= (r_beat == BURST_LEN - 1);
            rdata  <= DATA_W'(r_beat);
            bvalid <= (bvalid && !bready) || ((b_pend != 0) && !hold_resp);
        end
    end

endmodule

// File: tb/tb_hbm_traffic.sv
module tb_hbm_traffic;
    import hbm_traffic_pkg::*;

    logic              axi_aclk;
    logic              axi_aresetn;
    logic              start;
    logic [2:0]        mode;
    logic              address_inc;
    logic [31:0]       port_mask;
    logic              hold_resp;
    logic [ADDR_W-1:0] araddr;
    logic [ADDR_W-1:0] awaddr;
    logic [DATA_W-1:0] rdata;
    logic [DATA_W-1:0] wdata;
    logic              arvalid;
    logic              arready;
    logic              rlast;
    logic              rvalid;
    logic              rready;
    logic              awvalid;
    logic              awready;
    logic              wlast;
    logic              wvalid;
    logic              wready;
    logic              bvalid;
    logic              bready;
    logic              busy;

    string             test_name;
    int                errors;
    int                test_errors;      // Error count when the current test began
    int                tests;
    int                failed_tests;
    int                timeout_cycles = 20000;
    int                ar_k;
    int                aw_k;
    int                w_k;
    logic [ADDR_W-1:0] exp_addr;
    logic [DATA_W-1:0] exp_data;
    logic              exp_last;

    hbm_traffic_top #(.port_index(2), .region_bursts(8)) i_hbm_traffic_top (
        .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn), .start(start), .mode(mode),
        .address_inc(address_inc), .port_mask(port_mask),
        .araddr(araddr), .arvalid(arvalid), .arready(arready), .rdata(rdata),
        .rlast(rlast), .rvalid(rvalid), .rready(rready),
        .awaddr(awaddr), .awvalid(awvalid), .awready(awready), .wdata(wdata),
        .wlast(wlast), .wvalid(wvalid), .wready(wready), .bvalid(bvalid),
        .bready(bready), .busy(busy)
    );

    hbm_slave_model i_slave (
        .axi_aclk(axi_aclk), .axi_aresetn(axi_aresetn), .hold_resp(hold_resp),
        .arvalid(arvalid), .arready(arready), .rdata(rdata), .rlast(rlast),
        .rvalid(rvalid), .rready(rready), .awvalid(awvalid), .awready(awready),
        .wlast(wlast), .wvalid(wvalid), .wready(wready), .bvalid(bvalid),
        .bready(bready)
    );

    initial
    begin
        axi_aclk = 1'b0;
        forever #4 axi_aclk = ~axi_aclk;
    end

    // Region of port 2 in 0x200-byte bursts that wrap after 8
    function automatic logic [ADDR_W-1:0] expected_addr(input int k, input logic inc);
        logic [ADDR_W-1:0] base;
        base = ADDR_W'(2) * ADDR_W'(33'h10000000);
        if (inc)
            return base + ADDR_W'(k % 8) * ADDR_W'(33'h200);
        return base;
    endfunction

    ////////////////////////////////////////
    // Compare process
    ////////////////////////////////////////

    always @(posedge axi_aclk)
    begin
        if (!axi_aresetn)
        begin
            ar_k <= 0;
            aw_k <= 0;
            w_k  <= 0;
        end
        else
        begin
            if (arvalid && arready)
            begin
                exp_addr = expected_addr(ar_k, address_inc);
                assert (araddr == exp_addr)
                else
                begin
                    $display("MISMATCH %s araddr[%0d] expected %h actual %h",
                             test_name, ar_k, exp_addr, araddr);
                    errors++;
                end
                ar_k <= ar_k + 1;
            end
            if (awvalid && awready)
            begin
                exp_addr = expected_addr(aw_k, address_inc);
                assert (awaddr == exp_addr)
                else
                begin
                    $display("MISMATCH %s awaddr[%0d] expected %h actual %h",
                             test_name, aw_k, exp_addr, awaddr);
                    errors++;
                end
                aw_k <= aw_k + 1;
            end
            if (wvalid && wready)
            begin
                exp_data = {8{32'ha5a5a5a5}};
                exp_last = (w_k % 16) == 15;    // Sixteenth beat of each burst
                assert (wdata == exp_data)
                else
                begin
                    $display("MISMATCH %s wdata beat %0d expected %h actual %h",
                             test_name, w_k, exp_data, wdata);
                    errors++;
                end
                assert (wlast == exp_last)
                else
                begin
                    $display("MISMATCH %s wlast beat %0d expected %b actual %b",
                             test_name, w_k, exp_last, wlast);
                    errors++;
                end
                w_k <= w_k + 1;
            end
        end
    end

    ////////////////////////////////////////
    // Sequencing helpers
    ////////////////////////////////////////

    // Outputs while reset is still applied
    task automatic check_reset_state();
        logic [ADDR_W-1:0] base;
        base = expected_addr(0, 1'b0);
        assert (!arvalid && !awvalid && !wvalid && !wlast && !busy)
        else
        begin
            $display("%s: a valid, wlast or busy is high during reset", test_name);
            errors++;
        end
        assert (!rready && !bready)
        else
        begin
            $display("%s: rready or bready is high during reset", test_name);
            errors++;
        end
        assert (araddr == base)
        else
        begin
            $display("MISMATCH %s araddr in reset expected %h actual %h",
                     test_name, base, araddr);
            errors++;
        end
        assert (awaddr == base)
        else
        begin
            $display("MISMATCH %s awaddr in reset expected %h actual %h",
                     test_name, base, awaddr);
            errors++;
        end
    endtask

    task automatic begin_test(input string name, input logic [2:0] m, input logic inc,
                              input logic [31:0] mask);
        test_name   = name;
        test_errors = errors;
        mode        <= m;
        address_inc <= inc;
        port_mask   <= mask;
        hold_resp   <= 1'b0;
        axi_aresetn <= 1'b0;     // Fresh addresses and counters per test
        repeat (8) @(posedge axi_aclk);
        check_reset_state();
        axi_aresetn <= 1'b1;
        @(posedge axi_aclk);
        start <= 1'b1;
    endtask

    task automatic end_test();
        tests++;
        if (errors == test_errors)
            $display("%s: ok", test_name);
        else
        begin
            failed_tests++;
            $display("%s: failed with %0d errors", test_name, errors - test_errors);
        end
    endtask

    task automatic wait_bursts(input bit is_write, input int n);
        int cycles;
        int seen;
        cycles = 0;
        seen   = 0;
        while ((seen < n) && (cycles < timeout_cycles))
        begin
            @(posedge axi_aclk);
            seen = is_write ? i_slave.aw_count : i_slave.ar_count;
            cycles++;
        end
        if (seen < n)
        begin
            $display("%s: timed out with only %0d of %0d bursts accepted",
                     test_name, seen, n);
            errors++;
        end
    endtask

    task automatic stop_and_drain();
        int  cycles;
        bit  done;
        cycles = 0;
        done   = 1'b0;
        @(posedge axi_aclk);
        start <= 1'b0;
        while (!done && (cycles < timeout_cycles))
        begin
            @(posedge axi_aclk);
            done = !busy;
            cycles++;
        end
        if (!done)
        begin
            $display("%s: busy still high %0d cycles after start fell", test_name, cycles);
            errors++;
        end
    endtask

    ////////////////////////////////////////
    // Stimulus
    ////////////////////////////////////////

    initial
    begin
        axi_aresetn  = 1'b0;
        start        = 1'b0;
        mode         = 3'd0;
        address_inc  = 1'b0;
        port_mask    = '0;
        hold_resp    = 1'b0;
        errors       = 0;
        tests        = 0;
        failed_tests = 0;

        begin_test("queued_read", 3'd3, 1'b1, 32'h4);
        wait_bursts(1'b0, 20);      // Two and a half wraps of the 8-burst region
        stop_and_drain();
        end_test();

        begin_test("queued_write", 3'd4, 1'b1, 32'h4);
        wait_bursts(1'b1, 20);
        stop_and_drain();
        assert (i_slave.wlast_count == i_slave.aw_count)
        else
        begin
            $display("MISMATCH %s wlast count expected %0d actual %0d",
                     test_name, i_slave.aw_count, i_slave.wlast_count);
            errors++;
        end
        assert (i_slave.w_beats == 16 * i_slave.aw_count)
        else
        begin
            $display("MISMATCH %s W beats expected %0d actual %0d",
                     test_name, 16 * i_slave.aw_count, i_slave.w_beats);
            errors++;
        end
        assert (i_slave.b_count == i_slave.aw_count)
        else
        begin
            $display("MISMATCH %s write responses expected %0d actual %0d",
                     test_name, i_slave.aw_count, i_slave.b_count);
            errors++;
        end
        end_test();

        begin_test("fixed_address", 3'd3, 1'b0, 32'h4);
        wait_bursts(1'b0, 10);
        stop_and_drain();
        mode <= 3'd4;
        @(posedge axi_aclk);
        start <= 1'b1;
        wait_bursts(1'b1, 10);
        stop_and_drain();
        end_test();

        begin_test("outstanding_limit", 3'd3, 1'b1, 32'h4);
        hold_resp <= 1'b1;
        wait_bursts(1'b0, 32);
        repeat (100)
        begin
            @(posedge axi_aclk);
            assert (!arvalid)
            else
            begin
                $display("%s: arvalid rose with all responses held", test_name);
                errors++;
            end
        end
        assert (i_slave.ar_count == 32)
        else
        begin
            $display("MISMATCH %s AR handshakes expected %0d actual %0d",
                     test_name, 32, i_slave.ar_count);
            errors++;
        end
        hold_resp <= 1'b0;
        wait_bursts(1'b0, 40);      // Issuing resumes once responses return
        stop_and_drain();
        end_test();

        begin_test("stop_drain", 3'd3, 1'b1, 32'h4);
        wait_bursts(1'b0, 6);
        stop_and_drain();
        assert (i_slave.rlast_count == i_slave.ar_count)
        else
        begin
            $display("MISMATCH %s completed reads expected %0d actual %0d",
                     test_name, i_slave.ar_count, i_slave.rlast_count);
            errors++;
        end
        end_test();

        begin_test("port_mask", 3'd3, 1'b1, 32'hfffffffb);
        for (int i = 0; i < 200; i++)
        begin
            @(posedge axi_aclk);
            if (i == 100)
                mode <= 3'd4;
            assert (!arvalid && !awvalid)
            else
            begin
                $display("%s: address valid raised with the port masked off", test_name);
                errors++;
            end
        end
        start <= 1'b0;
        end_test();

        $display("Tests run: %0d, tests failed: %0d, errors: %0d", tests, failed_tests, errors);
        if (errors == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule
